//--- Bender.yml
package:
  name: aes256_device

sources:
  - hdl/aes_pkg.sv
  - hdl/cmd_queue.sv
  - hdl/aes_ctrl.sv
  - hdl/key_expander.sv
  - hdl/round_key_store.sv
  - hdl/aes_enc_core.sv
  - hdl/aes_dec_core.sv
  - hdl/aes256_device.sv
  - target: test
    files:
      - verif/aes256_device_sva.sv
      - verif/tb_aes256_device.sv

//--- files.f
hdl/aes_pkg.sv
hdl/cmd_queue.sv
hdl/aes_ctrl.sv
hdl/key_expander.sv
hdl/round_key_store.sv
hdl/aes_enc_core.sv
hdl/aes_dec_core.sv
hdl/aes256_device.sv
verif/aes256_device_sva.sv
verif/tb_aes256_device.sv

//--- hdl/aes256_device.sv
// key commands give no output; results leave in command order with variable latency
`timescale 1ns/1ps
`default_nettype none

module aes256_device
    import aes_pkg::*;
#(
    parameter int CMD_DEPTH = 8
)
(
    input  logic   clk,
    input  logic   resetn,
    input  cmd_t   in_cmd,
    input  logic   in_valid,
    output logic   in_ready,
    output block_t out_data,
    output logic   out_valid,
    input  logic   out_ready
);
    // queue head and controller handshakes
    cmd_t       head;
    logic       head_valid;
    logic       pop;
    logic       key_lo_load;
    logic       key_hi_load;
    block_t     key_half;
    logic       expand_done;
    // round key write and read paths
    logic       wr_en;
    round_idx_t wr_addr;
    block_t     wr_key;
    round_idx_t enc_addr;
    block_t     enc_rkey;
    round_idx_t dec_addr;
    block_t     dec_rkey;
    // core control and results
    logic       enc_start;
    logic       dec_start;
    block_t     blk_in;
    logic       enc_done;
    block_t     enc_out;
    logic       dec_done;
    block_t     dec_out;

    cmd_queue #(.CMD_DEPTH(CMD_DEPTH)) u_queue (
        .clk(clk), .resetn(resetn), .in_cmd(in_cmd), .in_valid(in_valid),
        .in_ready(in_ready), .pop(pop), .head(head), .head_valid(head_valid)
    );

    aes_ctrl u_ctrl (
        .clk(clk), .resetn(resetn), .head(head), .head_valid(head_valid), .pop(pop),
        .key_lo_load(key_lo_load), .key_hi_load(key_hi_load), .key_half(key_half),
        .expand_done(expand_done), .enc_start(enc_start), .dec_start(dec_start),
        .blk_in(blk_in), .enc_done(enc_done), .enc_out(enc_out), .dec_done(dec_done),
        .dec_out(dec_out), .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
    );

    key_expander u_expander (
        .clk(clk), .resetn(resetn), .key_lo_load(key_lo_load), .key_hi_load(key_hi_load),
        .key_half(key_half), .wr_en(wr_en), .wr_addr(wr_addr), .wr_key(wr_key),
        .expand_done(expand_done)
    );

    round_key_store u_store (
        .clk(clk), .resetn(resetn), .wr_en(wr_en), .wr_addr(wr_addr), .wr_key(wr_key),
        .enc_addr(enc_addr), .enc_rkey(enc_rkey), .dec_addr(dec_addr), .dec_rkey(dec_rkey)
    );

    aes_enc_core u_enc (
        .clk(clk), .resetn(resetn), .start(enc_start), .blk_in(blk_in), .rk_addr(enc_addr),
        .rkey(enc_rkey), .done(enc_done), .blk_out(enc_out)
    );

    aes_dec_core u_dec (
        .clk(clk), .resetn(resetn), .start(dec_start), .blk_in(blk_in), .rk_addr(dec_addr),
        .rkey(dec_rkey), .done(dec_done), .blk_out(dec_out)
    );

endmodule

`default_nettype wire

//--- hdl/aes_ctrl.sv
// one command in flight at a time; data commands wait at the queue head until a key is expanded
`timescale 1ns/1ps
`default_nettype none

module aes_ctrl
    import aes_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  cmd_t   head,
    input  logic   head_valid,
    output logic   pop,
    output logic   key_lo_load,
    output logic   key_hi_load,
    output block_t key_half,
    input  logic   expand_done,
    output logic   enc_start,
    output logic   dec_start,
    output block_t blk_in,
    input  logic   enc_done,
    input  block_t enc_out,
    input  logic   dec_done,
    input  block_t dec_out,
    output block_t out_data,
    output logic   out_valid,
    input  logic   out_ready
);
    typedef enum logic [2:0]
    {
        IDLE,
        KEY_EXPAND,
        ENC_RUN,
        DEC_RUN,
        RESULT
    } state_e;

    state_e state;
    state_e state_next;
    logic   key_ready;
    logic   is_key_op;

    // key halves never wait, data needs a finished schedule
    assign is_key_op = (head.op == OP_KEY_LO) || (head.op == OP_KEY_HI);
    assign pop       = (state == IDLE) && head_valid && (is_key_op || key_ready);

    // everything below is qualified by the pop itself
    assign key_lo_load = pop && (head.op == OP_KEY_LO);
    assign key_hi_load = pop && (head.op == OP_KEY_HI);
    assign enc_start   = pop && (head.op == OP_ENC);
    assign dec_start   = pop && (head.op == OP_DEC);
    assign key_half    = head.data;
    assign blk_in      = head.data;
    assign out_valid   = (state == RESULT);

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                // low half is latched by the expander, stay here
                if (key_hi_load)
                    state_next = KEY_EXPAND;
                else if (enc_start)
                    state_next = ENC_RUN;
                else if (dec_start)
                    state_next = DEC_RUN;
            end
            KEY_EXPAND:
                if (expand_done)
                    state_next = IDLE;
            ENC_RUN:
                if (enc_done)
                    state_next = RESULT;
            DEC_RUN:
                if (dec_done)
                    state_next = RESULT;
            RESULT:
                if (out_ready)
                    state_next = IDLE;
            default:
                state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state     <= IDLE;
            key_ready <= 1'b0;
            out_data  <= '0;
        end
        else
        begin
            state <= state_next;
            // old schedule is invalid as soon as rekeying starts
            if (key_hi_load)
                key_ready <= 1'b0;
            else if (expand_done)
                key_ready <= 1'b1;
            if ((state == ENC_RUN) && enc_done)
                out_data <= enc_out;
            else if ((state == DEC_RUN) && dec_done)
                out_data <= dec_out;
        end
    end

endmodule

`default_nettype wire

//--- hdl/aes_dec_core.sv
// direct inverse cipher with the stored encryption keys; start while busy restarts the block
`timescale 1ns/1ps
`default_nettype none

module aes_dec_core
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,
    input  block_t     blk_in,
    output round_idx_t rk_addr,
    input  block_t     rkey,
    output logic       done,
    output block_t     blk_out
);
    localparam round_idx_t LAST = round_idx_t'(NUM_ROUNDS);

    block_t     state;
    round_idx_t round;
    logic       busy;
    block_t     added;
    block_t     mixed;

    // InvShiftRows then InvSubBytes with rows rotating right
    function automatic block_t inv_sub_shift(input block_t s);
        block_t o;
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                o[127 - 8*(r + 4*c) -: 8] =
                    inv_sub_byte(s[127 - 8*(r + 4*((c - r + 4) % 4)) -: 8]);
        return o;
    endfunction

    function automatic block_t inv_mix_columns(input block_t s);
        block_t     o;
        logic [7:0] a [4];
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                a[r] = s[127 - 8*(r + 4*c) -: 8];
            for (int r = 0; r < 4; r++)
                o[127 - 8*(r + 4*c) -: 8] = gf_mul(a[r], 4'd14) ^ gf_mul(a[(r + 1) % 4], 4'd11)
                                            ^ gf_mul(a[(r + 2) % 4], 4'd13)
                                            ^ gf_mul(a[(r + 3) % 4], 4'd9);
        end
        return o;
    endfunction

    // key 14 is read while the block loads
    assign rk_addr = start ? LAST : round;
    assign blk_out = state;
    assign added   = inv_sub_shift(state) ^ rkey;
    // key 0 closes the cipher without InvMixColumns
    assign mixed   = (round == '0) ? added : inv_mix_columns(added);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy  <= 1'b0;
            round <= '0;
            done  <= 1'b0;
        end
        else
        begin
            done <= busy && (round == '0);
            if (start)
            begin
                busy  <= 1'b1;
                round <= LAST - 1'b1;
            end
            else if (busy)
            begin
                if (round == '0)
                    busy <= 1'b0;
                else
                    round <= round - 1'b1;
            end
        end
    end

    // key 14 is added as the block loads
    always_ff @(posedge clk)
    begin
        if (start)
            state <= blk_in ^ rkey;
        else if (busy)
            state <= mixed;
    end

endmodule

`default_nettype wire

//--- hdl/aes_enc_core.sv
// start while busy restarts the block; result valid from done until the next start
`timescale 1ns/1ps
`default_nettype none

module aes_enc_core
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,
    input  block_t     blk_in,
    output round_idx_t rk_addr,
    input  block_t     rkey,
    output logic       done,
    output block_t     blk_out
);
    localparam round_idx_t LAST = round_idx_t'(NUM_ROUNDS);

    block_t     state;
    round_idx_t round;
    logic       busy;
    block_t     shifted;
    block_t     mixed;

    // SubBytes folded into ShiftRows
    // byte n sits in row n%4 and column n/4
    function automatic block_t sub_shift(input block_t s);
        block_t o;
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                o[127 - 8*(r + 4*c) -: 8] = sub_byte(s[127 - 8*(r + 4*((c + r) % 4)) -: 8]);
        return o;
    endfunction

    function automatic block_t mix_columns(input block_t s);
        block_t     o;
        logic [7:0] a [4];
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
                a[r] = s[127 - 8*(r + 4*c) -: 8];
            for (int r = 0; r < 4; r++)
                o[127 - 8*(r + 4*c) -: 8] = gf_mul(a[r], 4'd2) ^ gf_mul(a[(r + 1) % 4], 4'd3)
                                            ^ a[(r + 2) % 4] ^ a[(r + 3) % 4];
        end
        return o;
    endfunction

    // key 0 is read while the block loads
    assign rk_addr = start ? '0 : round;
    assign blk_out = state;
    assign shifted = sub_shift(state);
    // final round has no MixColumns
    assign mixed   = (round == LAST) ? shifted : mix_columns(shifted);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy  <= 1'b0;
            round <= '0;
            done  <= 1'b0;
        end
        else
        begin
            done <= busy && (round == LAST);
            if (start)
            begin
                busy  <= 1'b1;
                round <= round_idx_t'(1);
            end
            else if (busy)
            begin
                if (round == LAST)
                    busy <= 1'b0;
                else
                    round <= round + 1'b1;
            end
        end
    end

    // initial key addition happens with the load
    always_ff @(posedge clk)
    begin
        if (start)
            state <= blk_in ^ rkey;
        else if (busy)
            state <= mixed ^ rkey;
    end

endmodule

`default_nettype wire

//--- hdl/aes_pkg.sv
// byte 0 of every block sits in bits 127:120 (FIPS-197 order); round count fixed for AES-256
`default_nettype none

package aes_pkg;

    // widths that carry a meaning
    typedef logic [127:0] block_t;
    typedef logic [31:0]  word_t;
    typedef logic [3:0]   round_idx_t;

    // operation field of a queued command
    typedef enum logic [1:0]
    {
        OP_ENC    = 2'd0,
        OP_DEC    = 2'd1,
        OP_KEY_LO = 2'd2,
        OP_KEY_HI = 2'd3
    } cmd_op_e;

    typedef struct packed
    {
        cmd_op_e op;
        block_t  data;
    } cmd_t;

    localparam int NUM_ROUNDS     = 14;
    localparam int NUM_ROUND_KEYS = NUM_ROUNDS + 1;

    // forward S-box, entry 0 is the leftmost byte
    localparam logic [0:255][7:0] SBOX = {
        128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // inverse S-box
    localparam logic [0:255][7:0] INV_SBOX = {
        128'h52096ad53036a538bf40a39e81f3d7fb, 128'h7ce339829b2fff87348e4344c4dee9cb,
        128'h547b9432a6c2233dee4c950b42fac34e, 128'h082ea16628d924b2765ba2496d8bd125,
        128'h72f8f66486689816d4a45ccc5d65b692, 128'h6c704850fdedb9da5e154657a78d9d84,
        128'h90d8ab008cbcd30af7e45805b8b34506, 128'hd02c1e8fca3f0f02c1afbd0301138a6b,
        128'h3a9111414f67dcea97f2cfcef0b4e673, 128'h96ac7422e7ad3585e2f937e81c75df6e,
        128'h47f11a711d29c5896fb7620eaa18be1b, 128'hfc563e4bc6d279209adbc0fe78cd5af4,
        128'h1fdda8338807c731b11210592780ec5f, 128'h60517fa919b54a0d2de57a9f93c99cef,
        128'ha0e03b4dae2af5b0c8ebbb3c83539961, 128'h172b047eba77d626e169146355210c7d
    };

    function automatic logic [7:0] sub_byte(input logic [7:0] b);
        return SBOX[b];
    endfunction

    function automatic logic [7:0] inv_sub_byte(input logic [7:0] b);
        return INV_SBOX[b];
    endfunction

    // multiply by x, reduced by the AES polynomial
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // product with a small constant, enough for 2, 3, 9, 11, 13 and 14
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [3:0] m);
        logic [7:0] acc;
        logic [7:0] pw;
        acc = 8'h00;
        pw  = a;
        for (int i = 0; i < 4; i++)
        begin
            if (m[i])
                acc ^= pw;
            pw = xtime(pw);
        end
        return acc;
    endfunction

endpackage

`default_nettype wire

//--- hdl/cmd_queue.sv
// in-order command FIFO; CMD_DEPTH of 2 or more, any value, no push while full
`timescale 1ns/1ps
`default_nettype none

module cmd_queue
    import aes_pkg::*;
#(
    parameter int CMD_DEPTH = 8
)
(
    input  logic clk,
    input  logic resetn,
    input  cmd_t in_cmd,
    input  logic in_valid,
    output logic in_ready,
    input  logic pop,
    output cmd_t head,
    output logic head_valid
);
    localparam int PTR_W = $clog2(CMD_DEPTH);
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    cmd_t             mem [CMD_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             take;

    // wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(CMD_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready   = (count != CNT_W'(CMD_DEPTH));
    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];
    assign push       = in_valid && in_ready;
    assign take       = pop && head_valid;

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_cmd;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (take)
                rd_ptr <= next_ptr(rd_ptr);
            // simultaneous push and pop leaves the count alone
            if (push && !take)
                count <= count + 1'b1;
            else if (take && !push)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/key_expander.sv
// low half must be loaded before the high half; a new high half restarts the schedule
`timescale 1ns/1ps
`default_nettype none

module key_expander
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       key_lo_load,
    input  logic       key_hi_load,
    input  block_t     key_half,
    output logic       wr_en,
    output round_idx_t wr_addr,
    output block_t     wr_key,
    output logic       expand_done
);
    localparam round_idx_t LAST = round_idx_t'(NUM_ROUND_KEYS - 1);

    block_t     lo_half;
    block_t     win_old;
    block_t     win_new;
    round_idx_t step;
    logic       busy;
    logic [7:0] rcon;
    word_t      temp;
    word_t      n0;
    word_t      n1;
    word_t      n2;
    word_t      n3;

    function automatic word_t sub_word(input word_t w);
        return {sub_byte(w[31:24]), sub_byte(w[23:16]), sub_byte(w[15:8]), sub_byte(w[7:0])};
    endfunction

    // oldest four words of the window are the key being written
    assign wr_en       = busy;
    assign wr_addr     = step;
    assign wr_key      = win_old;
    assign expand_done = busy && (step == LAST);

    always_comb
    begin
        // even steps start a new 8-word group
        if (step[0])
            temp = sub_word(win_new[31:0]);
        else
            temp = sub_word({win_new[23:0], win_new[31:24]}) ^ {rcon, 24'h000000};
        n0 = win_old[127:96] ^ temp;
        n1 = win_old[95:64] ^ n0;
        n2 = win_old[63:32] ^ n1;
        n3 = win_old[31:0] ^ n2;
    end

    // schedule window, slides by four words per cycle
    always_ff @(posedge clk)
    begin
        if (key_lo_load)
            lo_half <= key_half;
        if (key_hi_load)
        begin
            win_old <= lo_half;
            win_new <= key_half;
        end
        else if (busy)
        begin
            win_old <= win_new;
            win_new <= {n0, n1, n2, n3};
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy <= 1'b0;
            step <= '0;
            rcon <= 8'h01;
        end
        else if (key_hi_load)
        begin
            busy <= 1'b1;
            step <= '0;
            rcon <= 8'h01;
        end
        else if (busy)
        begin
            if (step == LAST)
                busy <= 1'b0;
            else
                step <= step + 1'b1;
            // rcon advances once per group
            if (!step[0])
                rcon <= xtime(rcon);
        end
    end

endmodule

`default_nettype wire

//--- hdl/round_key_store.sv
// reads are combinational; addresses above 14 are never issued by the cores
`timescale 1ns/1ps
`default_nettype none

module round_key_store
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       wr_en,
    input  round_idx_t wr_addr,
    input  block_t     wr_key,
    input  round_idx_t enc_addr,
    output block_t     enc_rkey,
    input  round_idx_t dec_addr,
    output block_t     dec_rkey
);
    block_t keys [NUM_ROUND_KEYS];

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            for (int i = 0; i < NUM_ROUND_KEYS; i++)
                keys[i] <= '0;
        end
        else if (wr_en)
            keys[wr_addr] <= wr_key;
    end

    // private read port per core
    assign enc_rkey = keys[enc_addr];
    assign dec_rkey = keys[dec_addr];

endmodule

`default_nettype wire

//--- verif/aes256_device_sva.sv
// bound into aes256_device; queue fill is modelled from the handshakes, failures go to fail_count
`timescale 1ns/1ps
`default_nettype none

module aes256_device_sva
    import aes_pkg::*;
#(
    parameter int CMD_DEPTH = 8
)
(
    input logic   clk,
    input logic   resetn,
    input block_t out_data,
    input logic   out_valid,
    input logic   out_ready,
    input logic   enc_start,
    input logic   enc_done,
    input logic   in_valid,
    input logic   in_ready,
    input logic   pop,
    input logic   head_valid
);
    int fail_count = 0;
    int occupancy;

    // commands held, from accepted pushes and taken pops
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            occupancy <= 0;
        else
            occupancy <= occupancy + int'(in_valid && in_ready) - int'(pop && head_valid);
    end

    // offered result stays put until taken
    assert property (@(posedge clk) disable iff (!resetn)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else
    begin
        $error("out_data or out_valid changed while out_ready was low");
        fail_count++;
    end

    // key addition with the load, then 14 rounds
    assert property (@(posedge clk) disable iff (!resetn)
        enc_start |=> !enc_done [*14] ##1 enc_done)
    else
    begin
        $error("enc_done did not follow enc_start at the fixed latency");
        fail_count++;
    end

    // back-pressure only when every slot is taken
    assert property (@(posedge clk) disable iff (!resetn)
        (!in_ready) == (occupancy == CMD_DEPTH))
    else
    begin
        $error("in_ready does not match the queue full condition");
        fail_count++;
    end

endmodule

bind aes256_device aes256_device_sva #(.CMD_DEPTH(CMD_DEPTH)) u_sva (
    .clk(clk), .resetn(resetn), .out_data(out_data), .out_valid(out_valid),
    .out_ready(out_ready), .enc_start(enc_start), .enc_done(enc_done), .in_valid(in_valid),
    .in_ready(in_ready), .pop(pop), .head_valid(head_valid)
);

`default_nettype wire

//--- verif/tb_aes256_device.sv
// drives one command per row; round-trip rows feed their ciphertext back as decrypt commands
`timescale 1ns/1ps
`default_nettype none

module tb_aes256_device
    import aes_pkg::*;
();
    localparam int CMD_DEPTH  = 8;
    localparam int N_RAND     = 12;
    localparam int N_ROWS     = 7 + N_RAND;
    localparam int MAX_CYCLES = N_ROWS * 40 + 100;

    // one stimulus row
    typedef struct packed
    {
        cmd_op_e op;
        block_t  data;
        logic    chk;
        logic    rt;
        block_t  exp;
        int      stall;
    } row_t;

    // one result still owed by the DUT
    typedef struct packed
    {
        logic   rt;
        block_t exp;
        int     stall;
        int     row;
    } expect_t;

    logic    clk;
    logic    resetn;
    cmd_t    in_cmd;
    logic    in_valid;
    logic    in_ready;
    block_t  out_data;
    logic    out_valid;
    logic    out_ready;

    row_t    rows [N_ROWS];
    block_t  ct [N_ROWS];
    expect_t exp_q [$];
    int      fb_row [$];
    integer  seed;
    int      n_outputs;
    int      n_recv;
    int      n_fed;
    int      tests;
    int      failed;
    int      errors;
    int      cycles;
    logic    full_seen;

    aes256_device #(.CMD_DEPTH(CMD_DEPTH)) u_dut (
        .clk(clk), .resetn(resetn), .in_cmd(in_cmd), .in_valid(in_valid), .in_ready(in_ready),
        .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // watchdog
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout after %0d cycles, %0d of %0d results seen", cycles, n_recv,
                     n_outputs);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic row_t make_row(input cmd_op_e op, input block_t data, input logic chk,
                                      input logic rt, input block_t exp, input int stall);
        row_t r;
        r.op    = op;
        r.data  = data;
        r.chk   = chk;
        r.rt    = rt;
        r.exp   = exp;
        r.stall = stall;
        return r;
    endfunction

    function automatic expect_t make_expect(input logic rt, input block_t exp, input int stall,
                                            input int row);
        expect_t e;
        e.rt    = rt;
        e.exp   = exp;
        e.stall = stall;
        e.row   = row;
        return e;
    endfunction

    // FIPS-197 C.3 key, then the all-zero key
    task automatic build_table();
        block_t r;
        rows[0] = make_row(OP_KEY_LO, 128'h000102030405060708090a0b0c0d0e0f, 1'b0, 1'b0, '0, 0);
        rows[1] = make_row(OP_KEY_HI, 128'h101112131415161718191a1b1c1d1e1f, 1'b0, 1'b0, '0, 0);
        rows[2] = make_row(OP_ENC, 128'h00112233445566778899aabbccddeeff, 1'b1, 1'b0,
                           128'h8ea2b7ca516745bfeafc49904b496089, 3);
        rows[3] = make_row(OP_DEC, 128'h8ea2b7ca516745bfeafc49904b496089, 1'b1, 1'b0,
                           128'h00112233445566778899aabbccddeeff, 5);
        rows[4] = make_row(OP_KEY_LO, '0, 1'b0, 1'b0, '0, 0);
        rows[5] = make_row(OP_KEY_HI, '0, 1'b0, 1'b0, '0, 0);
        rows[6] = make_row(OP_ENC, '0, 1'b1, 1'b0, 128'hdc95c078a2408989ad48a21492842087, 0);
        // random blocks; decryption has to give each one back
        for (int i = 0; i < N_RAND; i++)
        begin
            r = {$random(seed), $random(seed), $random(seed), $random(seed)};
            rows[7 + i] = make_row(OP_ENC, r, 1'b0, 1'b1, r, (i == 0) ? 30 : 2);
        end
        n_outputs = 0;
        for (int i = 0; i < N_ROWS; i++)
            n_outputs += rows[i].chk + 2 * rows[i].rt;
    endtask

    task automatic check_block(input string name, input block_t exp, input block_t got);
        assert (got === exp)
        else
        begin
            $display("mismatch at %0t ns: %s expected %h received %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        assert (got === exp)
        else
        begin
            $display("mismatch at %0t ns: %s expected %b received %b", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic finish_test(input string what, input int err_before);
        tests++;
        if (errors == err_before)
            $display("ok    %s", what);
        else
        begin
            failed++;
            $display("fail  %s", what);
        end
    endtask

    // called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic push_cmd(input cmd_op_e op, input block_t data);
        in_cmd.op   = op;
        in_cmd.data = data;
        in_valid    = 1'b1;
        while (!in_ready)
        begin
            full_seen = 1'b1;
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic drive_rows();
        int r;
        for (int i = 0; i < N_ROWS; i++)
        begin
            // expectation first, the result cannot beat it
            if (rows[i].chk || rows[i].rt)
                exp_q.push_back(make_expect(rows[i].rt, rows[i].exp, rows[i].stall, i));
            push_cmd(rows[i].op, rows[i].data);
        end
        // decrypt commands built from returned ciphertexts
        while (n_fed < N_RAND)
        begin
            if (fb_row.size() > 0)
            begin
                r = fb_row.pop_front();
                exp_q.push_back(make_expect(1'b0, rows[r].exp, 2, r));
                push_cmd(OP_DEC, ct[r]);
                n_fed++;
            end
            else
            begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic collect_results();
        expect_t e;
        block_t  held;
        int      err_before;
        string   what;
        while (n_recv < n_outputs)
        begin
            while (!out_valid)
            begin
                @(posedge clk);
                #1;
            end
            err_before = errors;
            held       = out_data;
            if (exp_q.size() == 0)
            begin
                $display("a result appeared at %0t ns with no command waiting for it", $time);
                errors++;
                e = make_expect(1'b0, '0, 0, 0);
            end
            else
                e = exp_q.pop_front();
            // out_ready low, result has to sit still
            repeat (e.stall)
            begin
                @(posedge clk);
                #1;
                check_bit("out_valid", 1'b1, out_valid);
                check_block("out_data", held, out_data);
            end
            out_ready = 1'b1;
            @(posedge clk);
            #1;
            out_ready = 1'b0;
            n_recv++;
            if (e.rt)
            begin
                ct[e.row] = held;
                fb_row.push_back(e.row);
                what = $sformatf("row %0d OP_ENC random block, ciphertext %h", e.row, held);
            end
            else
            begin
                check_block("out_data", e.exp, held);
                if (rows[e.row].rt)
                    what = $sformatf("row %0d OP_DEC round trip", e.row);
                else
                    what = $sformatf("row %0d %s", e.row, rows[e.row].op.name());
            end
            finish_test(what, err_before);
        end
    endtask

    initial
    begin
        int err_before;
        seed      = 32'hd2f38ec0;
        resetn    = 1'b0;
        in_cmd    = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        n_recv    = 0;
        n_fed     = 0;
        tests     = 0;
        failed    = 0;
        errors    = 0;
        cycles    = 0;
        full_seen = 1'b0;
        build_table();
        repeat (8) @(posedge clk);
        #1;
        resetn = 1'b1;

        err_before = errors;
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("in_ready", 1'b1, in_ready);
        finish_test("state after reset", err_before);

        fork
            drive_rows();
            collect_results();
        join

        err_before = errors;
        assert (full_seen)
        else
        begin
            $display("in_ready never fell although more commands than the queue holds were sent");
            errors++;
        end
        finish_test("queue back-pressure", err_before);

        // bound protocol checks keep their own count
        err_before = errors;
        assert (u_dut.u_sva.fail_count == 0)
        else
        begin
            $display("bound protocol assertions failed %0d times", u_dut.u_sva.fail_count);
            errors++;
        end
        finish_test("protocol assertions", err_before);

        $display("summary: %0d tests, %0d passed, %0d failed", tests, tests - failed, failed);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
